/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_id_stage -f list.f -Mdir obj_dir

run: compile
	./obj_dir/Vtb_id_stage | tee sim.log
	@if grep -q "Finished with errors" sim.log; then echo "FAIL"; exit 1; fi
	@grep -q "Finished with no errors" sim.log || (echo "FAIL"; exit 1)
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

/* hw/branch_unit.sv */
module branch_unit
    import rv_isa_pkg::*;
(
    input  logic [2:0] funct3_i,
    input  logic       is_jal_i,
    input  logic       is_jalr_i,
    input  logic       is_branch_i,
    input  word_t      reg1_i,
    input  word_t      reg2_i,
    input  word_t      pc_i,
    input  word_t      jal_target_i,
    input  word_t      br_target_i,
    input  word_t      jalr_offset_i,
    output logic       branch_flag_o,
    output word_t      branch_target_o,
    output word_t      link_addr_o
);

    logic cond_true;
    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(reg1_i) < $signed(reg2_i);
    assign lt_unsigned = reg1_i < reg2_i;

    always_comb begin
        case (funct3_i)
            F3_BEQ:  cond_true = (reg1_i == reg2_i);
            F3_BNE:  cond_true = (reg1_i != reg2_i);
            F3_BLT:  cond_true = lt_signed;
            F3_BGE:  cond_true = !lt_signed;
            F3_BLTU: cond_true = lt_unsigned;
            F3_BGEU: cond_true = !lt_unsigned;
            default: cond_true = 1'b0;
        endcase
    end

    always_comb begin
        branch_flag_o   = 1'b0;
        branch_target_o = '0;
        link_addr_o     = '0;
        if (is_jal_i) begin
            branch_flag_o   = 1'b1;
            branch_target_o = jal_target_i;
            link_addr_o     = pc_i + 32'd4;
        end else if (is_jalr_i) begin
            branch_flag_o   = 1'b1;
            branch_target_o = reg1_i + jalr_offset_i; // Forwarded rs1
            link_addr_o     = pc_i + 32'd4;
        end else if (is_branch_i && cond_true) begin
            branch_flag_o   = 1'b1;
            branch_target_o = br_target_i;
        end
    end

endmodule

/* hw/id_ctrl_pkg.sv */
package id_ctrl_pkg;

    // Operation code handed to execute
    typedef enum logic [7:0] {
        NOP  = 8'b00000000,
        OR   = 8'b00100101,
        AND  = 8'b00100100,
        XOR  = 8'b00100110,
        SLT  = 8'b00101010,
        SLTU = 8'b00101011,
        SLL  = 8'b01111100,
        SRL  = 8'b00000010,
        SRA  = 8'b00000011,
        ADD  = 8'b00100000,
        SUB  = 8'b00100010,
        LUI  = 8'b01010000
    } alu_op_e;

    // Which execute result path is written back
    typedef enum logic [2:0] {
        RES_NOP         = 3'b000,
        RES_LOGIC       = 3'b001,
        RES_SHIFT       = 3'b010,
        RES_ARITH       = 3'b100,
        RES_JUMP_BRANCH = 3'b110
    } alu_sel_e;

endpackage

/* hw/id_ex_reg.sv */
module id_ex_reg
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
#(
    parameter int CREDITS = 2
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      accept_i,
    input  logic      credit_i,
    input  alu_op_e   aluop_i,
    input  alu_sel_e  alusel_i,
    input  word_t     reg1_i,
    input  word_t     reg2_i,
    input  reg_addr_t wd_i,
    input  logic      wreg_i,
    input  logic      branch_flag_i,
    input  word_t     branch_target_i,
    input  word_t     link_addr_i,
    output logic      valid_o,
    output logic      stall_o,
    output alu_op_e   aluop_o,
    output alu_sel_e  alusel_o,
    output word_t     reg1_o,
    output word_t     reg2_o,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output logic      branch_flag_o,
    output word_t     branch_target_o,
    output word_t     link_addr_o
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o       <= 1'b0;
            wreg_o        <= 1'b0;
            branch_flag_o <= 1'b0;
            credit_cnt    <= CNT_W'(CREDITS);
        end else begin
            valid_o       <= accept_i; // One-cycle pulse
            wreg_o        <= accept_i && wreg_i;
            branch_flag_o <= accept_i && branch_flag_i;
            if (accept_i && !credit_i) begin
                credit_cnt <= credit_cnt - CNT_W'(1);
            end else if (!accept_i && credit_i) begin
                credit_cnt <= credit_cnt + CNT_W'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            aluop_o         <= aluop_i;
            alusel_o        <= alusel_i;
            reg1_o          <= reg1_i;
            reg2_o          <= reg2_i;
            wd_o            <= wd_i;
            branch_target_o <= branch_target_i;
            link_addr_o     <= link_addr_i;
        end
    end

    assign stall_o = (credit_cnt == '0); // Execute has no room left

endmodule

/* hw/id_stage.sv */
module id_stage
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
#(
    parameter int CREDITS = 2
) (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      inst_valid_i,
    input  word_t     inst_i,
    input  word_t     pc_i,
    output logic      stall_o,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    input  word_t     rs1_data_i,
    input  word_t     rs2_data_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    input  logic      credit_i,
    output logic      valid_o,
    output alu_op_e   aluop_o,
    output alu_sel_e  alusel_o,
    output word_t     reg1_o,
    output word_t     reg2_o,
    output reg_addr_t wd_o,
    output logic      wreg_o,
    output logic      branch_flag_o,
    output word_t     branch_target_o,
    output word_t     link_addr_o
);

    logic      accept;
    word_t     imm;
    word_t     jal_target;
    word_t     br_target;
    word_t     jalr_offset;
    alu_op_e   dec_aluop;
    alu_sel_e  dec_alusel;
    logic      dec_wreg;
    reg_addr_t dec_wd;
    logic      reg1_read;
    logic      reg2_read;
    logic      is_jal;
    logic      is_jalr;
    logic      is_branch;
    word_t     reg1;
    word_t     reg2;
    logic      br_flag;
    word_t     br_target_sel;
    word_t     link_addr;

    assign accept = inst_valid_i && !stall_o;

    imm_gen u_imm_gen (
        .inst_i        (inst_i),
        .pc_i          (pc_i),
        .imm_o         (imm),
        .jal_target_o  (jal_target),
        .br_target_o   (br_target),
        .jalr_offset_o (jalr_offset)
    );

    inst_decoder u_inst_decoder (
        .inst_i      (inst_i),
        .aluop_o     (dec_aluop),
        .alusel_o    (dec_alusel),
        .wreg_o      (dec_wreg),
        .wd_o        (dec_wd),
        .reg1_read_o (reg1_read),
        .reg2_read_o (reg2_read),
        .rs1_addr_o  (rs1_addr_o),
        .rs2_addr_o  (rs2_addr_o),
        .is_jal_o    (is_jal),
        .is_jalr_o   (is_jalr),
        .is_branch_o (is_branch)
    );

    operand_bypass u_bypass_rs1 (
        .reg_read_i  (reg1_read),
        .reg_addr_i  (rs1_addr_o),
        .reg_data_i  (rs1_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg1)
    );

    operand_bypass u_bypass_rs2 (
        .reg_read_i  (reg2_read),
        .reg_addr_i  (rs2_addr_o),
        .reg_data_i  (rs2_data_i),
        .imm_i       (imm),
        .ex_wreg_i   (ex_wreg_i),
        .ex_wd_i     (ex_wd_i),
        .ex_wdata_i  (ex_wdata_i),
        .mem_wreg_i  (mem_wreg_i),
        .mem_wd_i    (mem_wd_i),
        .mem_wdata_i (mem_wdata_i),
        .operand_o   (reg2)
    );

    branch_unit u_branch_unit (
        .funct3_i        (inst_i[14:12]),
        .is_jal_i        (is_jal),
        .is_jalr_i       (is_jalr),
        .is_branch_i     (is_branch),
        .reg1_i          (reg1),
        .reg2_i          (reg2),
        .pc_i            (pc_i),
        .jal_target_i    (jal_target),
        .br_target_i     (br_target),
        .jalr_offset_i   (jalr_offset),
        .branch_flag_o   (br_flag),
        .branch_target_o (br_target_sel),
        .link_addr_o     (link_addr)
    );

    id_ex_reg #(
        .CREDITS (CREDITS)
    ) u_id_ex_reg (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .accept_i        (accept),
        .credit_i        (credit_i),
        .aluop_i         (dec_aluop),
        .alusel_i        (dec_alusel),
        .reg1_i          (reg1),
        .reg2_i          (reg2),
        .wd_i            (dec_wd),
        .wreg_i          (dec_wreg),
        .branch_flag_i   (br_flag),
        .branch_target_i (br_target_sel),
        .link_addr_i     (link_addr),
        .valid_o         (valid_o),
        .stall_o         (stall_o),
        .aluop_o         (aluop_o),
        .alusel_o        (alusel_o),
        .reg1_o          (reg1_o),
        .reg2_o          (reg2_o),
        .wd_o            (wd_o),
        .wreg_o          (wreg_o),
        .branch_flag_o   (branch_flag_o),
        .branch_target_o (branch_target_o),
        .link_addr_o     (link_addr_o)
    );

endmodule

/* hw/imm_gen.sv */
module imm_gen
    import rv_isa_pkg::*;
(
    input  word_t inst_i,
    input  word_t pc_i,
    output word_t imm_o,
    output word_t jal_target_o,
    output word_t br_target_o,
    output word_t jalr_offset_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    word_t      imm_i_type;
    word_t      imm_j_type;
    word_t      imm_b_type;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];

    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};

    always_comb begin
        imm_o = '0;
        case (opcode)
            OPC_OP_IMM: begin
                if (funct3 == F3_SLL || funct3 == F3_SRL_SRA) begin
                    imm_o = {27'b0, inst_i[24:20]}; // shamt
                end else begin
                    imm_o = imm_i_type;
                end
            end
            OPC_LUI: imm_o = {inst_i[31:12], 12'h000};
            default: imm_o = '0;
        endcase
    end

    assign jal_target_o  = pc_i + imm_j_type;
    assign br_target_o   = pc_i + imm_b_type;
    assign jalr_offset_o = imm_i_type; // Added to rs1 in branch_unit

endmodule

/* hw/inst_decoder.sv */
module inst_decoder
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  word_t     inst_i,
    output alu_op_e   aluop_o,
    output alu_sel_e  alusel_o,
    output logic      wreg_o,
    output reg_addr_t wd_o,
    output logic      reg1_read_o,
    output logic      reg2_read_o,
    output reg_addr_t rs1_addr_o,
    output reg_addr_t rs2_addr_o,
    output logic      is_jal_o,
    output logic      is_jalr_o,
    output logic      is_branch_o
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt_op;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign alt_op = inst_i[30]; // funct7 bit selecting SUB and SRA

    // Fixed RISC-V field positions
    assign wd_o       = inst_i[11:7];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    always_comb begin
        aluop_o     = NOP;
        alusel_o    = RES_NOP;
        wreg_o      = 1'b0;
        reg1_read_o = 1'b0;
        reg2_read_o = 1'b0;
        is_jal_o    = 1'b0;
        is_jalr_o   = 1'b0;
        is_branch_o = 1'b0;

        case (opcode)
            OPC_OP_IMM, OPC_OP: begin
                wreg_o      = 1'b1;
                reg1_read_o = 1'b1;
                reg2_read_o = (opcode == OPC_OP);
                case (funct3)
                    F3_ADD_SUB: begin
                        // Only the register form has SUB
                        aluop_o  = (opcode == OPC_OP && alt_op) ? SUB : ADD;
                        alusel_o = RES_ARITH;
                    end
                    F3_SLT: begin
                        aluop_o  = SLT;
                        alusel_o = RES_ARITH;
                    end
                    F3_SLTU: begin
                        aluop_o  = SLTU;
                        alusel_o = RES_ARITH;
                    end
                    F3_XOR: begin
                        aluop_o  = XOR;
                        alusel_o = RES_LOGIC;
                    end
                    F3_OR: begin
                        aluop_o  = OR;
                        alusel_o = RES_LOGIC;
                    end
                    F3_AND: begin
                        aluop_o  = AND;
                        alusel_o = RES_LOGIC;
                    end
                    F3_SLL: begin
                        aluop_o  = SLL;
                        alusel_o = RES_SHIFT;
                    end
                    default: begin // F3_SRL_SRA
                        aluop_o  = alt_op ? SRA : SRL;
                        alusel_o = RES_SHIFT;
                    end
                endcase
            end
            OPC_LUI: begin
                wreg_o   = 1'b1;
                aluop_o  = LUI;
                alusel_o = RES_LOGIC;
            end
            OPC_JAL: begin
                wreg_o   = 1'b1;
                alusel_o = RES_JUMP_BRANCH;
                is_jal_o = 1'b1;
            end
            OPC_JALR: begin
                wreg_o      = 1'b1;
                alusel_o    = RES_JUMP_BRANCH;
                reg1_read_o = 1'b1;
                is_jalr_o   = 1'b1;
            end
            OPC_BRANCH: begin
                if (funct3 != 3'b010 && funct3 != 3'b011) begin // Two holes in the map
                    alusel_o    = RES_JUMP_BRANCH;
                    reg1_read_o = 1'b1;
                    reg2_read_o = 1'b1;
                    is_branch_o = 1'b1;
                end
            end
            default: begin
                aluop_o = NOP;
            end
        endcase
    end

endmodule

/* hw/operand_bypass.sv */
module operand_bypass
    import rv_isa_pkg::*;
(
    input  logic      reg_read_i,
    input  reg_addr_t reg_addr_i,
    input  word_t     reg_data_i,
    input  word_t     imm_i,
    input  logic      ex_wreg_i,
    input  reg_addr_t ex_wd_i,
    input  word_t     ex_wdata_i,
    input  logic      mem_wreg_i,
    input  reg_addr_t mem_wd_i,
    input  word_t     mem_wdata_i,
    output word_t     operand_o
);

    logic ex_hit;
    logic mem_hit;

    assign ex_hit  = ex_wreg_i && (ex_wd_i == reg_addr_i);
    assign mem_hit = mem_wreg_i && (mem_wd_i == reg_addr_i);

    // Youngest result wins
    always_comb begin
        if (!reg_read_i) begin
            operand_o = imm_i;
        end else if (ex_hit) begin
            operand_o = ex_wdata_i;
        end else if (mem_hit) begin
            operand_o = mem_wdata_i;
        end else begin
            operand_o = reg_data_i;
        end
    end

endmodule

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // funct3 for conditional branches
    localparam logic [2:0] F3_BEQ     = 3'b000;
    localparam logic [2:0] F3_BNE     = 3'b001;
    localparam logic [2:0] F3_BLT     = 3'b100;
    localparam logic [2:0] F3_BGE     = 3'b101;
    localparam logic [2:0] F3_BLTU    = 3'b110;
    localparam logic [2:0] F3_BGEU    = 3'b111;

endpackage

/* list.f */
hw/rv_isa_pkg.sv
hw/id_ctrl_pkg.sv
hw/imm_gen.sv
hw/inst_decoder.sv
hw/operand_bypass.sv
hw/branch_unit.sv
hw/id_ex_reg.sv
hw/id_stage.sv
testbench/tb_clk_gen.sv
testbench/tb_id_stage.sv

/* testbench/tb_clk_gen.sv */
module tb_clk_gen #(
    parameter int PERIOD = 4
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

/* testbench/tb_id_stage.sv */
module tb_id_stage
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
;

    localparam int    CREDIT_CYCLES = 10;
    localparam word_t D1 = 32'hffff_fff0; // -16 signed, large unsigned
    localparam word_t D2 = 32'h0000_0020;
    localparam word_t PC = 32'h0000_0100;

    typedef struct {
        string     name;
        word_t     inst, r1d, r2d, exd, memd, e1, e2, tgt, link;
        logic      exw, memw, wreg, bf;
        reg_addr_t exwd, memwd;
        alu_op_e   op;
        alu_sel_e  sel;
    } entry_t;

    logic clk, rst, inst_valid, stall, ex_wreg, mem_wreg, credit, valid, wreg, bflag;
    word_t inst, pc, rs1_data, rs2_data, ex_wdata, mem_wdata, reg1, reg2, btgt, link;
    reg_addr_t rs1_addr, rs2_addr, ex_wd, mem_wd, wd;
    alu_op_e aluop;
    alu_sel_e alusel;
    entry_t tbl[$];
    entry_t e;
    int errors = 0;
    int seed = 88;

    tb_clk_gen #(.PERIOD(4)) u_clk (.clk_o(clk));

    id_stage #(.CREDITS(2)) u_dut (
        .clk_i(clk), .rst_i(rst), .inst_valid_i(inst_valid), .inst_i(inst), .pc_i(pc),
        .stall_o(stall), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_wreg_i(ex_wreg), .ex_wd_i(ex_wd), .ex_wdata_i(ex_wdata),
        .mem_wreg_i(mem_wreg), .mem_wd_i(mem_wd), .mem_wdata_i(mem_wdata),
        .credit_i(credit), .valid_o(valid), .aluop_o(aluop), .alusel_o(alusel),
        .reg1_o(reg1), .reg2_o(reg2), .wd_o(wd), .wreg_o(wreg),
        .branch_flag_o(bflag), .branch_target_o(btgt), .link_addr_o(link)
    );

    // Encoders with rs1 = x1, rs2 = x2, rd = x5
    function automatic word_t enc_i(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc);
        return {imm, 5'd1, f3, 5'd5, opc};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd5, 7'b0110011};
    endfunction

    function automatic word_t enc_b(logic [12:0] off, logic [2:0] f3);
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd5, 7'b1101111};
    endfunction

    task automatic start(string n, word_t i, word_t a, word_t b);
        e = '{name: n, inst: i, r1d: a, r2d: b, exd: '0, memd: '0, e1: a, e2: b,
              tgt: '0, link: '0, exw: 1'b0, memw: 1'b0, wreg: 1'b1, bf: 1'b0,
              exwd: 5'd0, memwd: 5'd0, op: NOP, sel: RES_NOP};
    endtask

    task automatic add_alu(string n, word_t i, alu_op_e op, alu_sel_e sel, word_t e1, word_t e2);
        start(n, i, D1, D2);
        e.op = op;
        e.sel = sel;
        e.e1 = e1;
        e.e2 = e2;
        tbl.push_back(e);
    endtask

    task automatic add_br(string n, logic [2:0] f3, logic [12:0] off, word_t a, word_t b,
                          logic taken, word_t tgt);
        start(n, enc_b(off, f3), a, b);
        e.sel = RES_JUMP_BRANCH;
        e.wreg = 1'b0;
        e.bf = taken;
        e.tgt = taken ? tgt : 32'h0;
        tbl.push_back(e);
    endtask

    task automatic add_fwd(string n, logic exw, reg_addr_t exwd, logic memw, reg_addr_t memwd,
                           word_t e1);
        start(n, enc_r(7'h00, F3_ADD_SUB), D1, D2);
        {e.exw, e.exwd, e.exd} = {exw, exwd, 32'h1111_1111};
        {e.memw, e.memwd, e.memd} = {memw, memwd, 32'h2222_2222};
        e.op = ADD;
        e.sel = RES_ARITH;
        e.e1 = e1;
        tbl.push_back(e);
    endtask

    task automatic build_table();
        add_alu("addi", enc_i(12'hffb, F3_ADD_SUB, OPC_OP_IMM), ADD, RES_ARITH, D1, 32'hffff_fffb);
        add_alu("slti", enc_i(12'hffb, F3_SLT, OPC_OP_IMM), SLT, RES_ARITH, D1, 32'hffff_fffb);
        add_alu("xori", enc_i(12'h0f0, F3_XOR, OPC_OP_IMM), XOR, RES_LOGIC, D1, 32'h0000_00f0);
        add_alu("ori", enc_i(12'h800, F3_OR, OPC_OP_IMM), OR, RES_LOGIC, D1, 32'hffff_f800);
        add_alu("andi", enc_i(12'h7ff, F3_AND, OPC_OP_IMM), AND, RES_LOGIC, D1, 32'h0000_07ff);
        add_alu("slli", enc_i(12'h003, F3_SLL, OPC_OP_IMM), SLL, RES_SHIFT, D1, 32'd3);
        add_alu("srli", enc_i(12'h01f, F3_SRL_SRA, OPC_OP_IMM), SRL, RES_SHIFT, D1, 32'd31);
        add_alu("srai", enc_i(12'h407, F3_SRL_SRA, OPC_OP_IMM), SRA, RES_SHIFT, D1, 32'd7);
        add_alu("add", enc_r(7'h00, F3_ADD_SUB), ADD, RES_ARITH, D1, D2);
        add_alu("sub", enc_r(7'h20, F3_ADD_SUB), SUB, RES_ARITH, D1, D2);
        add_alu("slt", enc_r(7'h00, F3_SLT), SLT, RES_ARITH, D1, D2);
        add_alu("sltu", enc_r(7'h00, F3_SLTU), SLTU, RES_ARITH, D1, D2);
        add_alu("sll", enc_r(7'h00, F3_SLL), SLL, RES_SHIFT, D1, D2);
        add_alu("srl", enc_r(7'h00, F3_SRL_SRA), SRL, RES_SHIFT, D1, D2);
        add_alu("sra", enc_r(7'h20, F3_SRL_SRA), SRA, RES_SHIFT, D1, D2);
        add_alu("xor", enc_r(7'h00, F3_XOR), XOR, RES_LOGIC, D1, D2);
        add_alu("or", enc_r(7'h00, F3_OR), OR, RES_LOGIC, D1, D2);
        add_alu("and", enc_r(7'h00, F3_AND), AND, RES_LOGIC, D1, D2);
        add_alu("lui", {20'habcde, 5'd5, 7'b0110111}, LUI, RES_LOGIC, 32'habcde000, 32'habcde000);
        start("unknown", 32'h0000_02ff, D1, D2); // Opcode 1111111
        {e.e1, e.e2, e.wreg} = {32'h0, 32'h0, 1'b0};
        tbl.push_back(e);
        add_fwd("fwd_ex_mem", 1'b1, 5'd1, 1'b1, 5'd1, 32'h1111_1111);
        add_fwd("fwd_mem", 1'b1, 5'd3, 1'b1, 5'd1, 32'h2222_2222);
        add_fwd("fwd_off", 1'b0, 5'd1, 1'b0, 5'd1, D1);
        add_br("beq_t", F3_BEQ, 13'h0020, D2, D2, 1'b1, 32'h0000_0120);
        add_br("beq_n", F3_BEQ, 13'h0020, D1, D2, 1'b0, 32'h0);
        add_br("bne_t", F3_BNE, 13'h1ff8, D1, D2, 1'b1, 32'h0000_00f8);
        add_br("bne_n", F3_BNE, 13'h0020, D1, D1, 1'b0, 32'h0);
        add_br("blt_t", F3_BLT, 13'h0020, D1, D2, 1'b1, 32'h0000_0120);
        add_br("blt_n", F3_BLT, 13'h0020, D2, D1, 1'b0, 32'h0);
        add_br("bge_t", F3_BGE, 13'h0020, D2, D1, 1'b1, 32'h0000_0120);
        add_br("bge_n", F3_BGE, 13'h0020, D1, D2, 1'b0, 32'h0);
        add_br("bltu_t", F3_BLTU, 13'h0020, D2, D1, 1'b1, 32'h0000_0120);
        add_br("bltu_n", F3_BLTU, 13'h0020, D1, D2, 1'b0, 32'h0);
        add_br("bgeu_t", F3_BGEU, 13'h0020, D1, D2, 1'b1, 32'h0000_0120);
        add_br("bgeu_eq", F3_BGEU, 13'h0020, D2, D2, 1'b1, 32'h0000_0120);
        add_br("bgeu_n", F3_BGEU, 13'h0020, D2, D1, 1'b0, 32'h0);
        start("jal", enc_j(21'h000800), D1, D2);
        e.sel = RES_JUMP_BRANCH;
        e.e1 = 32'h0;
        e.e2 = 32'h0;
        e.bf = 1'b1;
        e.tgt = 32'h0000_0900;
        e.link = 32'h0000_0104;
        tbl.push_back(e);
        start("jalr", enc_i(12'hffc, 3'b000, OPC_JALR), D1, D2);
        {e.exw, e.exwd, e.exd} = {1'b1, 5'd1, 32'h0000_2000}; // rs1 from EX
        e.sel = RES_JUMP_BRANCH;
        e.e1 = 32'h0000_2000;
        e.e2 = 32'h0;
        e.bf = 1'b1;
        e.tgt = 32'h0000_1ffc;
        e.link = 32'h0000_0104;
        tbl.push_back(e);
    endtask

    task automatic check_alu_op(string n, alu_op_e exp, alu_op_e act);
        if (exp !== act) begin
            $display("ERR %s aluop exp %s act %s", n, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_alu_sel(string n, alu_sel_e exp, alu_sel_e act);
        if (exp !== act) begin
            $display("ERR %s alusel exp %s act %s", n, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_word(string n, word_t exp, word_t act);
        if (exp !== act) begin
            $display("ERR %s exp %h act %h", n, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(string n, reg_addr_t exp, reg_addr_t act);
        if (exp !== act) begin
            $display("ERR %s exp %0d act %0d", n, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(string n, logic exp, logic act);
        if (exp !== act) begin
            $display("ERR %s exp %b act %b", n, exp, act);
            errors++;
        end
    endtask

    task automatic drive(entry_t t);
        {inst, pc, rs1_data, rs2_data} = {t.inst, PC, t.r1d, t.r2d};
        {ex_wreg, ex_wd, ex_wdata} = {t.exw, t.exwd, t.exd};
        {mem_wreg, mem_wd, mem_wdata} = {t.memw, t.memwd, t.memd};
        inst_valid = 1'b1;
    endtask

    initial begin
        build_table();
        {rst, inst_valid, credit, ex_wreg, mem_wreg} = 5'b10000;
        {inst, pc, ex_wd, mem_wd, ex_wdata, mem_wdata} = '0;
        rs1_data = $random(seed);
        rs2_data = $random(seed);
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        check_bit("reset stall", 1'b0, stall);
        check_bit("reset valid", 1'b0, valid);
        check_bit("reset wreg", 1'b0, wreg);
        check_bit("reset branch_flag", 1'b0, bflag);
        foreach (tbl[i]) begin
            @(posedge clk);
            #1 credit = 1'b0;
            if (stall) begin
                $display("Unexpected stall before test %s", tbl[i].name);
                errors++;
            end
            drive(tbl[i]);
            @(posedge clk);
            #1 inst_valid = 1'b0;
            credit = 1'b1; // Execute frees the entry
            if (!valid) begin
                $display("No valid pulse for test %s", tbl[i].name);
                errors++;
            end
            check_alu_op(tbl[i].name, tbl[i].op, aluop);
            check_alu_sel(tbl[i].name, tbl[i].sel, alusel);
            check_word({tbl[i].name, " reg1"}, tbl[i].e1, reg1);
            check_word({tbl[i].name, " reg2"}, tbl[i].e2, reg2);
            if (tbl[i].wreg) check_addr({tbl[i].name, " wd"}, 5'd5, wd);
            check_bit({tbl[i].name, " wreg"}, tbl[i].wreg, wreg);
            check_bit({tbl[i].name, " branch_flag"}, tbl[i].bf, bflag);
            check_word({tbl[i].name, " target"}, tbl[i].tgt, btgt);
            check_word({tbl[i].name, " link"}, tbl[i].link, link);
        end

        // Back-pressure with both credits held by execute
        @(posedge clk);
        #1 credit = 1'b0;
        drive(tbl[8]);
        @(posedge clk);
        #1 check_bit("credit first accept stall", 1'b0, stall);
        check_addr("credit rs1_addr", 5'd1, rs1_addr);
        check_addr("credit rs2_addr", 5'd2, rs2_addr);
        @(posedge clk);
        #1 check_bit("credit stall raised", 1'b1, stall);
        @(posedge clk);
        #1 check_bit("credit held no valid", 1'b0, valid);
        credit = 1'b1;
        rs1_data = D2; // Register file written during the stall
        @(posedge clk);
        #1 credit = 1'b0;
        check_bit("credit stall lowered", 1'b0, stall);
        check_bit("credit still no valid", 1'b0, valid);
        @(posedge clk);
        #1 inst_valid = 1'b0;
        check_bit("credit held out", 1'b1, valid);
        check_word("credit held reg1", D2, reg1);
        @(posedge clk);
        #1 check_bit("credit single pulse", 1'b0, valid);

        $display("Checks done: %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #1;
        #((tbl.size() * 2 + CREDIT_CYCLES + 2) * 4 * 4);
        $display("Watchdog expired before the tests completed");
        $display("Finished with errors");
        $finish;
    end

endmodule
